//--- logic_sniffer.f
logic_sniffer_pkg.sv
trig_stage_if.sv
uart_rx.sv
uart_tx.sv
sump_cmd_decoder.sv
trigger_stage.sv
capture_ctrl.sv
logic_sniffer.sv
tb_logic_sniffer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the logic sniffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_logic_sniffer -f logic_sniffer.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_logic_sniffer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1

//--- tb_logic_sniffer.sv
/*
 * directed testbench for the logic sniffer
 * UART driver and monitor, compare tasks and the tests:
 * ID query, basic capture, low-byte mask, reset command, random stage 3
 */

`timescale 1ns/1ns

module tb_logic_sniffer;

  localparam int SEED_INIT   = 92580;
  localparam int BIT_CLKS    = 8;     // clocks per UART bit
  localparam int START_WAIT  = 2000;  // clocks allowed before a start bit
  localparam int SILENT_WAIT = 600;

  logic                       clk;
  logic                       rst;
  logic                       rx;
  logic                       tx;
  logic_sniffer_pkg::sample_t chls;

  integer seed;
  int     mismatches;
  int     failures;

  logic_sniffer logic_sniffer_inst (
    .clk_i  (clk),
    .rst_i  (rst),
    .chls_i (chls),
    .rx_i   (rx),
    .tx_o   (tx)
  );

  always #20 clk = ~clk;

  task automatic reset_dut;
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // start bit, data LSB first, stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
  endtask

  task automatic send_cmd(input logic [7:0] op, input logic [31:0] data);
    send_byte(op);
    for (int i = 0; i < 4; i++) send_byte(data[8*i +: 8]);  // low byte first
  endtask

  task automatic recv_byte(output logic [7:0] b, output logic ok);
    int waited;
    ok = 1'b0;
    b = '0;
    waited = 0;
    while (tx !== 1'b0 && waited < START_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("no start bit on tx_o within %0d clocks (time %0t)", START_WAIT, $time);
      failures++;
      return;
    end
    repeat (BIT_CLKS / 2) @(negedge clk);  // middle of the start bit
    if (tx !== 1'b0) begin
      $display("start bit on tx_o ended early (time %0t)", $time);
      failures++;
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = tx;
    end
    repeat (BIT_CLKS) @(negedge clk);
    if (tx !== 1'b1) begin
      $display("missing stop bit on tx_o (time %0t)", $time);
      failures++;
      return;
    end
    ok = 1'b1;
  endtask

  task automatic recv_sample(output logic_sniffer_pkg::sample_t s, output logic ok);
    logic [7:0] b;
    s = '0;
    for (int i = 0; i < 4; i++) begin
      recv_byte(b, ok);
      if (!ok) return;
      s[8*i +: 8] = b;
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_sample(input logic_sniffer_pkg::sample_t got,
                              input logic_sniffer_pkg::sample_t exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_silent(input int clocks, input string what);
    for (int i = 0; i < clocks; i++) begin
      @(negedge clk);
      if (tx === 1'b0) begin
        $display("unexpected start bit on tx_o during %s (time %0t)", what, $time);
        failures++;
        return;
      end
    end
  endtask

  task automatic set_stage(input int n, input logic [31:0] mask, input logic [31:0] value);
    send_cmd(8'(8'hC0 + 4 * n), mask);
    send_cmd(8'(8'hC1 + 4 * n), value);
  endtask

  task automatic set_counts(input int rd, input int dly);
    send_cmd(8'h81, {16'(rd), 16'(dly)});
  endtask

  // hold the word on the channels while the samples come back
  task automatic capture_and_check(input logic_sniffer_pkg::sample_t word, input int n,
                                   input string what);
    logic_sniffer_pkg::sample_t s;
    logic                       ok;
    chls = word;
    for (int i = 0; i < n; i++) begin
      recv_sample(s, ok);
      if (!ok) break;
      check_sample(s, word, $sformatf("%s sample %0d", what, i));
    end
    chls = '0;
    check_silent(SILENT_WAIT, $sformatf("%s after the last sample", what));
  endtask

  task automatic test_id_query;
    logic [7:0] exp [4];
    logic [7:0] b;
    logic       ok;
    exp = '{8'h31, 8'h41, 8'h4C, 8'h53};  // "1ALS"
    send_byte(8'h02);
    for (int i = 0; i < 4; i++) begin
      recv_byte(b, ok);
      if (!ok) break;
      check_byte(b, exp[i], $sformatf("ID byte %0d", i));
    end
  endtask

  task automatic test_basic_capture;
    set_stage(0, 32'hFFFF_FFFF, 32'hDEAD_BEEF);
    set_counts(8, 16);  // read no more than delay, so only post-trigger samples return
    send_byte(8'h01);
    capture_and_check(32'hDEAD_BEEF, 8, "basic capture");
  endtask

  task automatic test_mask;
    set_stage(1, 32'h0000_00FF, 32'h0000_00A5);
    send_byte(8'h01);
    capture_and_check(32'h1234_56A5, 8, "low byte mask");
    send_byte(8'h01);
    chls = 32'h1234_565A;  // low byte differs
    check_silent(SILENT_WAIT, "mask mismatch");
    chls = '0;
  endtask

  task automatic test_reset_cmd;
    send_byte(8'h01);
    send_byte(8'h00);
    set_counts(8, 16);  // the reset command also cleared the counts
    chls = 32'h1234_56A5;  // would match stage 1 if still armed
    check_silent(SILENT_WAIT, "reset command");
    chls = '0;
  endtask

  task automatic test_random_stage(input int run);
    logic_sniffer_pkg::sample_t rv;
    rv = $random(seed);
    if (rv == '0) rv = 32'h1;  // idle channels are zero
    reset_dut();
    set_stage(3, 32'hFFFF_FFFF, rv);
    set_counts(4, 8);
    send_byte(8'h01);
    capture_and_check(rv, 4, $sformatf("random stage run %0d", run));
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    rx         = 1'b1;
    chls       = '0;
    seed       = SEED_INIT;
    mismatches = 0;
    failures   = 0;
    @(negedge clk);
    reset_dut();

    test_id_query();
    test_basic_capture();
    test_mask();
    test_reset_cmd();
    test_random_stage(0);
    test_random_stage(1);

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- logic_sniffer.sv
/*
 * logic sniffer top level
 * UART receiver, command decoder, trigger stages, capture controller
 * and UART transmitter
 */

`timescale 1ns/1ns

module logic_sniffer (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [logic_sniffer_pkg::SAMPLE_W-1:0] chls_i,
  input  logic                                   rx_i,
  output logic                                   tx_o
);

  logic_sniffer_pkg::sump_cmd_t         cmd;
  logic                                 cmd_stb;
  logic                                 run_stb;
  logic                                 clr_stb;
  logic                                 id_stb;
  logic [logic_sniffer_pkg::ADDR_W:0]   read_count;
  logic [logic_sniffer_pkg::ADDR_W:0]   delay_count;
  logic [logic_sniffer_pkg::BYTE_W-1:0] tx_data;
  logic                                 tx_stb;
  logic                                 tx_rdy;

  trig_stage_if stage_if [logic_sniffer_pkg::NUM_STAGES] ();

  uart_rx uart_rx_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rx_i      (rx_i),
    .cmd_o     (cmd),
    .cmd_stb_o (cmd_stb)
  );

  sump_cmd_decoder sump_cmd_decoder_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_i         (cmd),
    .cmd_stb_i     (cmd_stb),
    .stage_o       (stage_if),
    .run_stb_o     (run_stb),
    .clr_stb_o     (clr_stb),
    .id_stb_o      (id_stb),
    .read_count_o  (read_count),
    .delay_count_o (delay_count)
  );

  for (genvar g = 0; g < logic_sniffer_pkg::NUM_STAGES; g++) begin : gen_stage
    trigger_stage trigger_stage_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .chls_i   (chls_i),
      .stage_io (stage_if[g])
    );
  end

  capture_ctrl capture_ctrl_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .chls_i        (chls_i),
    .stage_i       (stage_if),
    .run_stb_i     (run_stb),
    .clr_stb_i     (clr_stb),
    .id_stb_i      (id_stb),
    .read_count_i  (read_count),
    .delay_count_i (delay_count),
    .tx_data_o     (tx_data),
    .tx_stb_o      (tx_stb),
    .tx_rdy_i      (tx_rdy)
  );

  uart_tx uart_tx_inst (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (tx_data),
    .stb_i  (tx_stb),
    .rdy_o  (tx_rdy),
    .tx_o   (tx_o)
  );

endmodule

//--- capture_ctrl.sv
/*
 * capture controller
 * ring buffer, trigger OR, post-trigger count and byte-wise readout,
 * plus the ID reply through the same send path
 */

`timescale 1ns/1ns

module capture_ctrl (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic_sniffer_pkg::sample_t           chls_i,
  trig_stage_if.capture                        stage_i [logic_sniffer_pkg::NUM_STAGES],
  input  logic                                 run_stb_i,
  input  logic                                 clr_stb_i,
  input  logic                                 id_stb_i,
  input  logic [logic_sniffer_pkg::ADDR_W:0]   read_count_i,
  input  logic [logic_sniffer_pkg::ADDR_W:0]   delay_count_i,
  output logic [logic_sniffer_pkg::BYTE_W-1:0] tx_data_o,
  output logic                                 tx_stb_o,
  input  logic                                 tx_rdy_i
);

  logic_sniffer_pkg::sample_t               mem [logic_sniffer_pkg::MEM_DEPTH];
  logic [logic_sniffer_pkg::ADDR_W-1:0]     wr_ptr;
  logic [logic_sniffer_pkg::ADDR_W-1:0]     rd_ptr;
  logic [1:0]                               state;
  logic [logic_sniffer_pkg::NUM_STAGES-1:0] stage_match;
  logic                                     trig;
  logic                                     wr_en;
  logic [logic_sniffer_pkg::ADDR_W:0]       post_cnt;    // writes left after the trigger
  logic [logic_sniffer_pkg::ADDR_W:0]       words_left;
  logic_sniffer_pkg::sample_t               tx_word;
  logic                                     word_valid;  // tx_word holds the next word
  logic [1:0]                               byte_idx;

  for (genvar g = 0; g < logic_sniffer_pkg::NUM_STAGES; g++) begin : gen_match
    assign stage_match[g] = stage_i[g].match;
  end

  assign trig  = |stage_match;
  assign wr_en = state == logic_sniffer_pkg::CAP_ARMED ||
                 (state == logic_sniffer_pkg::CAP_POST && post_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (wr_en) mem[wr_ptr] <= chls_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state      <= logic_sniffer_pkg::CAP_IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      post_cnt   <= '0;
      words_left <= '0;
      word_valid <= 1'b0;
      byte_idx   <= '0;
      tx_stb_o   <= 1'b0;
    end else begin
      tx_stb_o <= 1'b0;
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (clr_stb_i) begin
        state <= logic_sniffer_pkg::CAP_IDLE;
      end else begin
        case (state)
          logic_sniffer_pkg::CAP_IDLE: begin
            if (run_stb_i) begin
              state <= logic_sniffer_pkg::CAP_ARMED;
            end else if (id_stb_i) begin
              tx_word    <= logic_sniffer_pkg::ID_WORD;
              word_valid <= 1'b1;
              words_left <= (logic_sniffer_pkg::ADDR_W + 1)'(1);
              byte_idx   <= '0;
              state      <= logic_sniffer_pkg::CAP_SEND;
            end
          end
          logic_sniffer_pkg::CAP_ARMED: begin
            if (trig) begin  // the trigger sample itself is written this cycle
              post_cnt <= delay_count_i;
              state    <= logic_sniffer_pkg::CAP_POST;
            end
          end
          logic_sniffer_pkg::CAP_POST: begin
            if (post_cnt != '0) begin
              post_cnt <= post_cnt - 1'b1;
            end else begin
              rd_ptr     <= wr_ptr - 1'b1;  // newest sample
              words_left <= read_count_i;
              word_valid <= 1'b0;
              state      <= logic_sniffer_pkg::CAP_SEND;
            end
          end
          default: begin
            if (words_left == '0) begin
              state <= logic_sniffer_pkg::CAP_IDLE;
            end else if (!word_valid) begin
              tx_word    <= mem[rd_ptr];
              rd_ptr     <= rd_ptr - 1'b1;  // walk backwards through the ring
              word_valid <= 1'b1;
              byte_idx   <= '0;
            end else if (tx_rdy_i && !tx_stb_o) begin
              // tx_rdy_i only drops the cycle after the strobe
              tx_stb_o  <= 1'b1;
              tx_data_o <= tx_word[byte_idx*logic_sniffer_pkg::BYTE_W +:
                                   logic_sniffer_pkg::BYTE_W];
              byte_idx  <= byte_idx + 1'b1;
              if (byte_idx == 2'd3) begin
                word_valid <= 1'b0;
                words_left <= words_left - 1'b1;
              end
            end
          end
        endcase
      end
    end
  end

  a_stb_rdy: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_stb_o |-> tx_rdy_i)
    else $error("tx strobe while transmitter busy");

  a_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
    (state == logic_sniffer_pkg::CAP_IDLE || state == logic_sniffer_pkg::CAP_SEND)
      |=> $stable(wr_ptr))
    else $error("sample written outside capture");

endmodule

//--- trigger_stage.sv
/*
 * one trigger stage
 * masked compare of the channels against the stored value
 */

`timescale 1ns/1ns

module trigger_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic_sniffer_pkg::sample_t chls_i,
  trig_stage_if.stage                stage_io
);

  logic_sniffer_pkg::sample_t diff;
  logic                       hit;

  assign diff = (chls_i ^ stage_io.value) & stage_io.mask;  // ones where a cared bit differs
  assign hit  = stage_io.armed && (diff == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) stage_io.match <= 1'b0;
    else stage_io.match <= hit;
  end

  a_no_match_unarmed: assert property (@(posedge clk_i) disable iff (rst_i)
    !stage_io.armed |=> !stage_io.match)
    else $error("trigger stage matched while unarmed");

endmodule

//--- sump_cmd_decoder.sv
/*
 * SUMP command decoder
 * per-stage mask, value and armed flag, read and delay counts,
 * run, reset and ID strobes for the capture controller
 */

`timescale 1ns/1ns

module sump_cmd_decoder (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic_sniffer_pkg::sump_cmd_t         cmd_i,
  input  logic                                 cmd_stb_i,
  trig_stage_if.decoder                        stage_o [logic_sniffer_pkg::NUM_STAGES],
  output logic                                 run_stb_o,
  output logic                                 clr_stb_o,
  output logic                                 id_stb_o,
  output logic [logic_sniffer_pkg::ADDR_W:0]   read_count_o,
  output logic [logic_sniffer_pkg::ADDR_W:0]   delay_count_o
);

  logic [logic_sniffer_pkg::BYTE_W-1:0]           opcode;
  logic [$clog2(logic_sniffer_pkg::NUM_STAGES)-1:0] stage_sel;
  logic                                           is_mask;
  logic                                           is_value;

  function automatic logic [logic_sniffer_pkg::ADDR_W:0] clamp_count(input logic [15:0] cnt);
    if (cnt > 16'(logic_sniffer_pkg::MEM_DEPTH)) return logic_sniffer_pkg::MAX_COUNT;
    return cnt[logic_sniffer_pkg::ADDR_W:0];
  endfunction

  assign opcode    = cmd_i.opcode;
  assign stage_sel = opcode[3:2];
  assign is_mask   = (opcode & logic_sniffer_pkg::OP_STAGE_SEL) == logic_sniffer_pkg::OP_MASK_BASE;
  assign is_value  = (opcode & logic_sniffer_pkg::OP_STAGE_SEL) == logic_sniffer_pkg::OP_VALUE_BASE;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_stb_o     <= 1'b0;
      clr_stb_o     <= 1'b0;
      id_stb_o      <= 1'b0;
      read_count_o  <= '0;
      delay_count_o <= '0;
    end else begin
      run_stb_o <= cmd_stb_i && opcode == logic_sniffer_pkg::OP_RUN;
      clr_stb_o <= cmd_stb_i && opcode == logic_sniffer_pkg::OP_RESET;
      id_stb_o  <= cmd_stb_i && opcode == logic_sniffer_pkg::OP_ID;
      if (cmd_stb_i && opcode == logic_sniffer_pkg::OP_RESET) begin
        read_count_o  <= '0;
        delay_count_o <= '0;
      end else if (cmd_stb_i && opcode == logic_sniffer_pkg::OP_COUNTS) begin
        read_count_o  <= clamp_count(cmd_i.data.counts.read_count);
        delay_count_o <= clamp_count(cmd_i.data.counts.delay_count);
      end
    end
  end

  for (genvar g = 0; g < logic_sniffer_pkg::NUM_STAGES; g++) begin : gen_stage_cfg
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        stage_o[g].mask  <= '0;
        stage_o[g].value <= '0;
        stage_o[g].armed <= 1'b0;
      end else if (cmd_stb_i) begin
        if (is_mask && stage_sel == 2'(g)) stage_o[g].mask <= cmd_i.data.raw;
        if (is_value && stage_sel == 2'(g)) stage_o[g].value <= cmd_i.data.raw;
        // stages with an empty mask stay out of the trigger
        if (opcode == logic_sniffer_pkg::OP_RUN) stage_o[g].armed <= |stage_o[g].mask;
        else if (opcode == logic_sniffer_pkg::OP_RESET) stage_o[g].armed <= 1'b0;
      end
    end
  end

endmodule

//--- uart_tx.sv
/*
 * UART transmitter, one byte per strobe
 * start bit, eight data bits LSB first, stop bit
 */

`timescale 1ns/1ns

module uart_tx (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [logic_sniffer_pkg::BYTE_W-1:0] data_i,
  input  logic                                 stb_i,
  output logic                                 rdy_o,
  output logic                                 tx_o
);

  logic [logic_sniffer_pkg::BYTE_W+1:0] shreg;  // stop, data, start
  logic [logic_sniffer_pkg::BAUD_W-1:0] baud_cnt;
  logic [3:0]                           bit_idx;

  assign tx_o = shreg[0];  // ones shift in behind the frame, so the line idles high

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      shreg    <= '1;
      rdy_o    <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (rdy_o) begin
      if (stb_i) begin
        shreg    <= {1'b1, data_i, 1'b0};
        rdy_o    <= 1'b0;
        baud_cnt <= logic_sniffer_pkg::BAUD_LAST;
        bit_idx  <= '0;
      end
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end else begin
      baud_cnt <= logic_sniffer_pkg::BAUD_LAST;
      shreg    <= {1'b1, shreg[logic_sniffer_pkg::BYTE_W+1:1]};
      if (bit_idx == 4'd9) rdy_o <= 1'b1;  // stop bit done
      else bit_idx <= bit_idx + 1'b1;
    end
  end

  // the sender has to wait for ready, a byte offered while busy is lost
  a_stb_when_rdy: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i |-> rdy_o)
    else $error("uart_tx strobed while busy");

endmodule

//--- uart_rx.sv
/*
 * UART receiver with command assembly
 * short opcodes strobe at once, long ones collect four data bytes, LSB first
 */

`timescale 1ns/1ns

module uart_rx (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         rx_i,
  output logic_sniffer_pkg::sump_cmd_t cmd_o,
  output logic                         cmd_stb_o
);

  logic                                   rx_meta;
  logic                                   rx_sync;
  logic                                   busy;
  logic [logic_sniffer_pkg::BAUD_W-1:0]   baud_cnt;
  logic [3:0]                             bit_idx;   // 0 start, 1..8 data, 9 stop
  logic [logic_sniffer_pkg::BYTE_W-1:0]   rx_byte;
  logic [2:0]                             byte_cnt;  // 0 waits for an opcode

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy      <= 1'b0;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      byte_cnt  <= '0;
      cmd_stb_o <= 1'b0;
    end else begin
      cmd_stb_o <= 1'b0;
      if (!busy) begin
        if (!rx_sync) begin
          busy     <= 1'b1;
          baud_cnt <= logic_sniffer_pkg::BAUD_HALF;
          bit_idx  <= '0;
        end
      end else if (baud_cnt != '0) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= logic_sniffer_pkg::BAUD_LAST;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == 4'd0 && rx_sync) begin
          busy <= 1'b0;  // glitch, line back high at mid start bit
        end else if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
          rx_byte <= {rx_sync, rx_byte[logic_sniffer_pkg::BYTE_W-1:1]};
        end else if (bit_idx == 4'd9) begin
          busy <= 1'b0;
          if (rx_sync && byte_cnt == '0) begin
            cmd_o.opcode   <= rx_byte;
            cmd_o.data.raw <= '0;
            if (rx_byte[logic_sniffer_pkg::LONG_CMD_BIT]) byte_cnt <= 3'd1;
            else cmd_stb_o <= 1'b1;
          end else if (rx_sync) begin
            // data arrives low byte first, so shift in from the top
            cmd_o.data.raw <= {rx_byte,
                               cmd_o.data.raw[logic_sniffer_pkg::SAMPLE_W-1:
                                              logic_sniffer_pkg::BYTE_W]};
            if (byte_cnt == 3'(logic_sniffer_pkg::CMD_W / logic_sniffer_pkg::BYTE_W - 1)) begin
              byte_cnt  <= '0;
              cmd_stb_o <= 1'b1;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
      end
    end
  end

  // a command needs at least one full byte time, so strobes never touch
  a_stb_single: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_stb_o |=> !cmd_stb_o)
    else $error("cmd_stb_o high on two consecutive cycles");

endmodule

//--- trig_stage_if.sv
/*
 * configuration and match result of one trigger stage
 * modports for the decoder, the stage and the capture controller
 */

`timescale 1ns/1ns

interface trig_stage_if;

  logic_sniffer_pkg::sample_t mask;
  logic_sniffer_pkg::sample_t value;
  logic                       armed;
  logic                       match;  // registered in the stage

  modport decoder (output mask, output value, output armed);

  modport stage (input mask, input value, input armed, output match);

  modport capture (input match);

endinterface

//--- logic_sniffer_pkg.sv
/*
 * shared widths, UART timing and SUMP opcodes for the logic sniffer
 * command and sample types, including the two views of command data
 * capture FSM state codes
 */

package logic_sniffer_pkg;

  localparam int CHANNELS    = 32;
  localparam int SAMPLE_W    = CHANNELS;
  localparam int NUM_STAGES  = 4;
  localparam int MEM_DEPTH   = 64;
  localparam int ADDR_W      = 6;
  localparam int CLK_PER_BIT = 8;
  localparam int BYTE_W      = 8;
  localparam int CMD_W       = 40;  // opcode byte plus four data bytes

  // bit-time counter, loaded with half a bit to find the middle of the start bit
  localparam int BAUD_W = $clog2(CLK_PER_BIT);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLK_PER_BIT - 1);
  localparam logic [BAUD_W-1:0] BAUD_HALF = BAUD_W'(CLK_PER_BIT / 2 - 1);

  // counts are clamped to the ring buffer depth
  localparam logic [ADDR_W:0] MAX_COUNT = MEM_DEPTH[ADDR_W:0];

  localparam logic [BYTE_W-1:0] OP_RESET      = 8'h00;
  localparam logic [BYTE_W-1:0] OP_RUN        = 8'h01;
  localparam logic [BYTE_W-1:0] OP_ID         = 8'h02;
  localparam logic [BYTE_W-1:0] OP_COUNTS     = 8'h81;
  localparam logic [BYTE_W-1:0] OP_MASK_BASE  = 8'hC0;  // + 4 * stage
  localparam logic [BYTE_W-1:0] OP_VALUE_BASE = 8'hC1;  // + 4 * stage
  localparam logic [BYTE_W-1:0] OP_STAGE_SEL  = 8'hF3;  // clears the stage field
  localparam int                LONG_CMD_BIT  = 7;

  // words go out low byte first, so "1ALS" sits reversed in the word
  localparam logic [SAMPLE_W-1:0] ID_WORD = 32'h534C_4131;

  localparam logic [1:0] CAP_IDLE  = 2'd0;
  localparam logic [1:0] CAP_ARMED = 2'd1;
  localparam logic [1:0] CAP_POST  = 2'd2;
  localparam logic [1:0] CAP_SEND  = 2'd3;

  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    logic [15:0] read_count;   // samples sent back
    logic [15:0] delay_count;  // samples stored after the trigger
  } counts_t;

  typedef union packed {
    sample_t raw;     // trigger mask or value
    counts_t counts;
  } cmd_data_u;

  typedef struct packed {
    logic [BYTE_W-1:0] opcode;
    cmd_data_u         data;
  } sump_cmd_t;

endpackage
